// ==== common/icache_pkg.sv ====
`default_nettype none

package icache_pkg;

  // --------------------------------------------------
  // Cache geometry
  // --------------------------------------------------
  localparam int XLEN       = 32;
  localparam int BLOCK_SIZE = 16;                         // Bytes per line
  localparam int BURST_SIZE = BLOCK_SIZE / (XLEN / 8);    // Beats per line fill
  localparam int SETS       = 64;

  localparam int IDX_BITS   = $clog2(SETS);
  localparam int OFFS_BITS  = $clog2(BLOCK_SIZE);
  localparam int TAG_BITS   = XLEN - IDX_BITS - OFFS_BITS;
  localparam int BLK_BITS   = 8 * BLOCK_SIZE;
  localparam int WORD_BITS  = $clog2(BURST_SIZE);         // Word within line
  localparam int BYTE_BITS  = $clog2(XLEN / 8);           // Byte within word

  // Flat view goes to the bus, field view indexes the arrays
  typedef union packed {
    logic [XLEN-1:0] flat;
    struct packed {
      logic [TAG_BITS-1:0]  tag;
      logic [IDX_BITS-1:0]  idx;
      logic [WORD_BITS-1:0] word;
      logic [BYTE_BITS-1:0] byte_offs;
    } f;
  } icache_adr_t;

endpackage

`default_nettype wire

// ==== common/icache_fill_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface icache_fill_if import icache_pkg::*; ();

  logic                fill_o;      // One-cycle line write
  logic [IDX_BITS-1:0] fill_idx;
  logic [TAG_BITS-1:0] fill_tag;
  logic [BLK_BITS-1:0] fill_line;
  logic                inval_o;     // Clear all ways of one set
  logic [IDX_BITS-1:0] inval_idx;

  modport ctrl (
    output fill_o, fill_idx, fill_tag, fill_line, inval_o, inval_idx
  );

  modport mem (
    input  fill_o, fill_idx, fill_tag, fill_line, inval_o, inval_idx
  );

endinterface

`default_nettype wire

// ==== icache/icache_memory.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_memory
  import icache_pkg::*;
#(
  parameter int WAYS = 2
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic [IDX_BITS-1:0] rd_idx_i,
  input  wire logic [TAG_BITS-1:0] cmp_tag_i,
  output logic                     hit_o,
  output logic [BLK_BITS-1:0]      line_o,
  icache_fill_if.mem               fill
);

  logic [IDX_BITS-1:0] rd_idx_q;
  logic [6:0]          way_random;
  logic [WAYS-1:0]     fill_way;               // One-hot
  logic [WAYS-1:0]     way_hit;                // One-hot or zero
  logic [BLK_BITS-1:0] way_line [WAYS];

  // --------------------------------------------------
  // Read index, one cycle ahead of the compare
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) rd_idx_q <= '0;
    else         rd_idx_q <= rd_idx_i;
  end

  // --------------------------------------------------
  // Random replacement
  // --------------------------------------------------
  // XNOR feedback, so the all-zero reset value is a legal state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)          way_random <= '0;
    else if (!fill.fill_o) way_random <= {way_random[5:0], way_random[6] ~^ way_random[5]};
  end

  if (WAYS == 1) begin : g_direct
    assign fill_way = 1'b1;
  end else begin : g_assoc
    assign fill_way = WAYS'(1) << way_random[$clog2(WAYS)-1:0];
  end

  // --------------------------------------------------
  // Per-way arrays
  // --------------------------------------------------
  for (genvar w = 0; w < WAYS; w++) begin : g_way
    logic [TAG_BITS-1:0] tag_mem  [SETS];
    logic [BLK_BITS-1:0] data_mem [SETS];
    logic [SETS-1:0]     valid_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q <= '0;
      end else if (fill.inval_o) begin
        valid_q[fill.inval_idx] <= 1'b0;       // All ways of the set
      end else if (fill.fill_o && fill_way[w]) begin
        valid_q[fill.fill_idx] <= 1'b1;
      end
    end

    always_ff @(posedge clk_i) begin
      if (fill.fill_o && fill_way[w]) begin
        tag_mem[fill.fill_idx]  <= fill.fill_tag;
        data_mem[fill.fill_idx] <= fill.fill_line;
      end
    end

    // Read after the registered index, so a fill is visible next cycle
    assign way_hit[w]  = valid_q[rd_idx_q] && (tag_mem[rd_idx_q] == cmp_tag_i);
    assign way_line[w] = way_hit[w] ? data_mem[rd_idx_q] : '0;
  end

  always_comb begin
    line_o = '0;
    for (int w = 0; w < WAYS; w++) begin
      line_o = line_o | way_line[w];         // Only the hitting way is non-zero
    end
  end

  assign hit_o = |way_hit;

  // The control stage only refills a line that missed, so a tag never
  // lands in two ways of one set
  a_hit_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_ni) $onehot0(way_hit)
  );

endmodule

`default_nettype wire

// ==== icache/icache_biu_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_biu_ctrl
  import icache_pkg::*;
(
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  input  wire logic            fetch_req_i,
  input  wire logic [XLEN-1:0] fetch_adr_i,
  output logic                 fetch_done_o,
  output logic                 fetch_err_o,
  output logic [BLK_BITS-1:0]  fetch_line_o,
  output logic                 biu_stb_o,
  output logic [XLEN-1:0]      biu_adri_o,
  input  wire logic            biu_stb_ack_i,
  input  wire logic            biu_ack_i,
  input  wire logic            biu_err_i,
  input  wire logic [XLEN-1:0] biu_q_i
);

  localparam logic [1:0] IDLE  = 2'd0;
  localparam logic [1:0] REQ   = 2'd1;
  localparam logic [1:0] BEATS = 2'd2;
  localparam int         CNT_BITS = $clog2(BURST_SIZE);

  logic [1:0]          state_q;
  logic [CNT_BITS-1:0] beat_cnt;
  logic                err_q, done_q, start;
  logic [BLK_BITS-1:0] line_q;
  logic [XLEN-1:0]     adr_q;

  // Request is still high in the done cycle, so don't restart then
  assign start = (state_q == IDLE) && fetch_req_i && !done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      beat_cnt <= '0;
      err_q    <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        IDLE: if (start) begin
          state_q  <= REQ;
          beat_cnt <= '0;
          err_q    <= 1'b0;
        end
        REQ: if (biu_stb_ack_i) state_q <= BEATS;
        BEATS: if (biu_ack_i) begin
          beat_cnt <= beat_cnt + 1'b1;
          err_q    <= err_q || biu_err_i;    // Sticky over the whole line
          if (&beat_cnt) begin
            state_q <= IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Beats arrive in address order from the line base
  always_ff @(posedge clk_i) begin
    if (start) adr_q <= fetch_adr_i;
    if (state_q == BEATS && biu_ack_i) line_q[beat_cnt*XLEN +: XLEN] <= biu_q_i;
  end

  assign biu_stb_o    = (state_q == REQ);
  assign biu_adri_o   = adr_q;
  assign fetch_done_o = done_q;
  assign fetch_err_o  = err_q;
  assign fetch_line_o = line_q;

  a_no_ack_idle : assert property (
    @(posedge clk_i) disable iff (!rst_ni) state_q == IDLE |-> !biu_ack_i
  );

endmodule

`default_nettype wire

// ==== icache/icache_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl
  import icache_pkg::*;
#(
  parameter int WAYS = 2
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic                mem_req_i,
  input  wire logic [XLEN-1:0]     mem_adr_i,
  input  wire logic                mem_flush_i,
  input  wire logic                cache_flush_i,
  output logic                     mem_stall_o,
  output logic [XLEN-1:0]          parcel_o,
  output logic                     parcel_valid_o,
  output logic                     parcel_error_o,
  output logic [IDX_BITS-1:0]      rd_idx_o,
  input  wire logic                hit_i,
  input  wire logic [BLK_BITS-1:0] line_i,
  icache_fill_if.ctrl              fill,
  output logic                     fetch_req_o,
  output logic [XLEN-1:0]          fetch_adr_o,
  input  wire logic                fetch_done_i,
  input  wire logic                fetch_err_i,
  input  wire logic [BLK_BITS-1:0] fetch_line_i
);

  localparam logic [1:0] RUN     = 2'd0;
  localparam logic [1:0] FETCH   = 2'd1;
  localparam logic [1:0] FLUSH   = 2'd2;
  localparam logic [1:0] RECOVER = 2'd3;       // Drains the burst after a pipeline flush

  if (WAYS != 1 && WAYS != 2 && WAYS != 4) begin : g_ways_check
    $error("icache_ctrl: WAYS must be 1, 2 or 4");
  end

  icache_adr_t         setup_adr, tag_adr;
  logic                setup_vld, tag_vld;
  logic [1:0]          state_q, state_d;
  logic                flush_pend, flush_req, miss;
  logic [IDX_BITS-1:0] flush_cnt;
  logic [BLK_BITS-1:0] line_sel;

  assign miss      = tag_vld && !hit_i && !mem_flush_i;
  assign flush_req = cache_flush_i || flush_pend;

  // --------------------------------------------------
  // Hit stage FSM
  // --------------------------------------------------
  always_comb begin
    state_d        = state_q;
    mem_stall_o    = 1'b1;
    parcel_valid_o = 1'b0;
    case (state_q)
      RUN: begin
        mem_stall_o    = miss || flush_req;
        parcel_valid_o = tag_vld && hit_i && !mem_flush_i && !flush_req;
        if (miss)           state_d = FETCH;   // Miss wins over a cache flush
        else if (flush_req) state_d = FLUSH;
      end
      FETCH: begin
        mem_stall_o    = !fetch_done_i;
        parcel_valid_o = fetch_done_i && !mem_flush_i;
        if (fetch_done_i)     state_d = RUN;
        else if (mem_flush_i) state_d = RECOVER;
      end
      RECOVER: begin
        mem_stall_o = !fetch_done_i;
        if (fetch_done_i) state_d = RUN;
      end
      default: begin                         // FLUSH
        if (&flush_cnt) state_d = RUN;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= RUN;
      flush_pend <= 1'b0;
      flush_cnt  <= '0;
      setup_vld  <= 1'b0;
      tag_vld    <= 1'b0;
    end else begin
      state_q    <= state_d;
      flush_pend <= flush_req && (state_d != FLUSH);  // Held while a fetch runs
      if (state_q == FLUSH) flush_cnt <= flush_cnt + 1'b1;
      if (mem_flush_i) begin
        setup_vld <= 1'b0;
        tag_vld   <= 1'b0;
      end else if (!mem_stall_o) begin
        setup_vld <= mem_req_i;
        tag_vld   <= setup_vld;
      end
    end
  end

  // Setup and tag stage addresses
  always_ff @(posedge clk_i) begin
    if (!mem_stall_o && !mem_flush_i) begin
      setup_adr.flat <= mem_adr_i;
      tag_adr        <= setup_adr;
    end
  end

  assign rd_idx_o = setup_adr.f.idx;

  // --------------------------------------------------
  // Parcel, fetch and array writes
  // --------------------------------------------------
  assign line_sel       = (state_q == RUN) ? line_i : fetch_line_i;
  assign parcel_o       = line_sel[tag_adr.f.word*XLEN +: XLEN];
  assign parcel_error_o = (state_q == FETCH) && fetch_err_i;

  assign fetch_req_o = (state_q == FETCH) || (state_q == RECOVER);
  assign fetch_adr_o = {tag_adr.flat[XLEN-1:OFFS_BITS], {OFFS_BITS{1'b0}}};  // Line base

  assign fill.fill_o    = fetch_req_o && fetch_done_i && !fetch_err_i;
  assign fill.fill_idx  = tag_adr.f.idx;
  assign fill.fill_tag  = tag_adr.f.tag;
  assign fill.fill_line = fetch_line_i;
  assign fill.inval_o   = (state_q == FLUSH);
  assign fill.inval_idx = flush_cnt;

  // Request and line address both stay put until the burst ends
  a_fetch_held : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    fetch_req_o && !fetch_done_i |=> fetch_req_o && $stable(fetch_adr_o)
  );

  // A flushed set cannot hit, so no parcel in the first cycle back in RUN either
  a_no_parcel_flush : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (state_q == FLUSH || $past(state_q) == FLUSH) |-> !parcel_valid_o
  );

endmodule

`default_nettype wire

// ==== icache/icache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_top
  import icache_pkg::*;
#(
  parameter int WAYS = 2
) (
  input  wire logic            clk_i,
  input  wire logic            rst_ni,

  // CPU side
  input  wire logic            mem_req_i,
  input  wire logic [XLEN-1:0] mem_adr_i,
  input  wire logic            mem_flush_i,
  input  wire logic            cache_flush_i,
  output logic                 mem_stall_o,
  output logic [XLEN-1:0]      parcel_o,
  output logic                 parcel_valid_o,
  output logic                 parcel_error_o,

  // Bus side
  output logic                 biu_stb_o,
  output logic [XLEN-1:0]      biu_adri_o,
  input  wire logic            biu_stb_ack_i,
  input  wire logic            biu_ack_i,
  input  wire logic            biu_err_i,
  input  wire logic [XLEN-1:0] biu_q_i
);

  logic [IDX_BITS-1:0] rd_idx;
  logic                cache_hit;
  logic [BLK_BITS-1:0] cache_line;
  logic                fetch_req, fetch_done, fetch_err;
  logic [XLEN-1:0]     fetch_adr;
  logic [BLK_BITS-1:0] fetch_line;

  icache_fill_if u_fill_if ();

  icache_ctrl #(.WAYS(WAYS)) u_ctrl (
    .clk_i, .rst_ni,
    .mem_req_i, .mem_adr_i, .mem_flush_i, .cache_flush_i,
    .mem_stall_o, .parcel_o, .parcel_valid_o, .parcel_error_o,
    .rd_idx_o     (rd_idx),
    .hit_i        (cache_hit),
    .line_i       (cache_line),
    .fill         (u_fill_if.ctrl),
    .fetch_req_o  (fetch_req),
    .fetch_adr_o  (fetch_adr),
    .fetch_done_i (fetch_done),
    .fetch_err_i  (fetch_err),
    .fetch_line_i (fetch_line)
  );

  icache_memory #(.WAYS(WAYS)) u_memory (
    .clk_i, .rst_ni,
    .rd_idx_i  (rd_idx),
    .cmp_tag_i (u_fill_if.fill_tag),  // Tag stage tag, also the fill tag
    .hit_o     (cache_hit),
    .line_o    (cache_line),
    .fill      (u_fill_if.mem)
  );

  icache_biu_ctrl u_biu_ctrl (
    .clk_i, .rst_ni,
    .fetch_req_i  (fetch_req),
    .fetch_adr_i  (fetch_adr),
    .fetch_done_o (fetch_done),
    .fetch_err_o  (fetch_err),
    .fetch_line_o (fetch_line),
    .biu_stb_o, .biu_adri_o, .biu_stb_ack_i, .biu_ack_i, .biu_err_i, .biu_q_i
  );

endmodule

`default_nettype wire

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD     = 40,
  parameter int RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Release just after an edge, like the other stimulus
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// ==== test/tb_icache.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_icache
  import icache_pkg::*;
();

  localparam logic [1:0] SINGLE = 2'd0;
  localparam logic [1:0] PAIR   = 2'd1;    // Paired with the next entry back to back
  localparam logic [1:0] CFLUSH = 2'd2;    // Cache flush before the request
  localparam logic [1:0] PFLUSH = 2'd3;    // Pipeline flush right after the request
  localparam logic [1:0] ANY    = 2'd2;    // Either a hit or a refill
  localparam int         WAIT_CYCLES = 150;

  typedef struct packed {
    logic [XLEN-1:0] adr;
    logic [1:0]      kind;
    logic            inj_err;
    logic [XLEN-1:0] exp_word;
    logic            exp_err;
    logic [1:0]      exp_fetch;    // Number of bursts or ANY
  } test_t;

  logic            clk_i, rst_ni;
  logic            mem_req_i, mem_flush_i, cache_flush_i;
  logic [XLEN-1:0] mem_adr_i, parcel_o;
  logic            mem_stall_o, parcel_valid_o, parcel_error_o;
  logic            biu_stb_o, biu_stb_ack_i, biu_ack_i, biu_err_i;
  logic [XLEN-1:0] biu_adri_o, biu_q_i;

  test_t           tests [$];
  logic [XLEN-1:0] par_word [$];
  logic            par_err [$];
  int              par_cycle [$];
  int              cycle = 0;
  int              seed = 5;
  int              bursts = 0;
  logic [XLEN-1:0] burst_adr;
  logic            inject_err = 1'b0;
  int              errors = 0;

  tb_clk_gen #(.PERIOD(40), .RST_CYCLES(3)) u_clk_gen (.clk_o(clk_i), .rst_no(rst_ni));

  icache_top #(.WAYS(2)) u_dut (.*);

  always @(posedge clk_i) cycle <= cycle + 1;

  // Sampled mid-cycle away from the edge
  always @(negedge clk_i) begin
    if (rst_ni && parcel_valid_o) begin
      par_word.push_back(parcel_o);
      par_err.push_back(parcel_error_o);
      par_cycle.push_back(cycle);
    end
  end

  // --------------------------------------------------
  // Bus memory model
  // --------------------------------------------------
  initial begin : bus_model
    int          delay;
    logic [XLEN-1:0] base;
    biu_stb_ack_i = 1'b0;
    biu_ack_i     = 1'b0;
    biu_err_i     = 1'b0;
    biu_q_i       = '0;
    forever begin
      @(negedge clk_i);
      if (biu_stb_o) begin
        base      = biu_adri_o;
        burst_adr = base;
        bursts++;
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(posedge clk_i);
        @(posedge clk_i);
        #1 biu_stb_ack_i = 1'b1;
        @(posedge clk_i);
        #1 biu_stb_ack_i = 1'b0;
        for (int b = 0; b < BURST_SIZE; b++) begin
          biu_ack_i = 1'b1;
          biu_q_i   = (base + 4 * b) ^ 32'hA5A5_0000;
          biu_err_i = inject_err && (b == 2);    // One bad beat spoils the line
          @(posedge clk_i);
          #1;
        end
        biu_ack_i = 1'b0;
        biu_err_i = 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic add_test(input logic [XLEN-1:0] adr, input logic [1:0] kind,
                          input logic inj_err, input logic [XLEN-1:0] exp_word,
                          input logic exp_err, input logic [1:0] exp_fetch);
    tests.push_back(test_t'{adr, kind, inj_err, exp_word, exp_err, exp_fetch});
  endtask

  task automatic check_value(input string sig, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    assert (got === exp) else begin
      $display("error %s: got %h, expected %h", sig, got, exp);
      errors++;
    end
  endtask

  // Called just after an edge, returns just after the accepting edge
  task automatic send_req(input logic [XLEN-1:0] adr, output int acc_cycle);
    int n;
    n = 0;
    mem_req_i = 1'b1;
    mem_adr_i = adr;
    @(negedge clk_i);
    while (mem_stall_o && n < WAIT_CYCLES) begin
      @(negedge clk_i);
      n++;
    end
    assert (!mem_stall_o) else begin
      $display("request to %h was not accepted within %0d cycles", adr, WAIT_CYCLES);
      errors++;
    end
    acc_cycle = cycle;
    @(posedge clk_i);
    #1 mem_req_i = 1'b0;
  endtask

  task automatic flush_cache();
    int stall_cycles;
    stall_cycles  = 0;
    cache_flush_i = 1'b1;
    @(posedge clk_i);
    #1 cache_flush_i = 1'b0;
    @(negedge clk_i);
    while (mem_stall_o && stall_cycles < 4 * SETS) begin
      stall_cycles++;
      @(negedge clk_i);
    end
    check_value("mem_stall_o cycles", stall_cycles, SETS);    // One per set
    @(posedge clk_i);
    #1;
  endtask

  // --------------------------------------------------
  // Stimulus table and checking loop
  // --------------------------------------------------
  initial begin : stimulus
    test_t t, e;
    int    acc [2];
    int    n_exp, par_base, burst_base, got, n, errs_before, failed;
    mem_req_i     = 1'b0;
    mem_adr_i     = '0;
    mem_flush_i   = 1'b0;
    cache_flush_i = 1'b0;
    failed        = 0;
    add_test(32'h0000_1044, SINGLE, 1'b0, 32'hA5A5_1044, 1'b0, 2'd1);  // Cold miss
    add_test(32'h0000_1048, SINGLE, 1'b0, 32'hA5A5_1048, 1'b0, 2'd0);
    add_test(32'h0000_104C, PAIR,   1'b0, 32'hA5A5_104C, 1'b0, 2'd0);
    add_test(32'h0000_1040, PAIR,   1'b0, 32'hA5A5_1040, 1'b0, 2'd0);
    add_test(32'h0000_1044, CFLUSH, 1'b0, 32'hA5A5_1044, 1'b0, 2'd1);
    add_test(32'h0000_2084, SINGLE, 1'b1, 32'hA5A5_2084, 1'b1, 2'd1);  // Line not kept
    add_test(32'h0000_2084, SINGLE, 1'b0, 32'hA5A5_2084, 1'b0, 2'd1);
    add_test(32'h0000_3004, PFLUSH, 1'b0, 32'h0000_0000, 1'b0, 2'd0);
    add_test(32'h0000_4108, SINGLE, 1'b0, 32'hA5A5_4108, 1'b0, 2'd1);  // Set 0x10
    add_test(32'h0000_8108, SINGLE, 1'b0, 32'hA5A5_8108, 1'b0, 2'd1);
    add_test(32'h0000_C108, SINGLE, 1'b0, 32'hA5A5_C108, 1'b0, 2'd1);
    add_test(32'h0000_4104, SINGLE, 1'b0, 32'hA5A5_4104, 1'b0, ANY);
    add_test(32'h0000_810C, SINGLE, 1'b0, 32'hA5A5_810C, 1'b0, ANY);

    wait (rst_ni === 1'b1);
    @(posedge clk_i);
    #1;
    for (int i = 0; i < tests.size(); i++) begin
      t           = tests[i];
      errs_before = errors;
      par_base    = par_word.size();
      burst_base  = bursts;
      inject_err  = t.inj_err;
      n_exp       = (t.kind == PFLUSH) ? 0 : (t.kind == PAIR) ? 2 : 1;
      if (t.kind == CFLUSH) flush_cache();
      send_req(t.adr, acc[0]);
      if (t.kind == PAIR) send_req(tests[i + 1].adr, acc[1]);
      if (t.kind == PFLUSH) begin
        mem_flush_i = 1'b1;
        @(posedge clk_i);
        #1 mem_flush_i = 1'b0;
      end
      n = 0;
      while ((n_exp == 0 || par_word.size() < par_base + n_exp) && n < WAIT_CYCLES) begin
        @(posedge clk_i);
        n++;
        if (n_exp == 0 && n == 10) break;                 // Quiet window
      end
      repeat (2) @(posedge clk_i);                        // Catch stray parcels
      #1;
      got = par_word.size() - par_base;
      assert (got == n_exp) else begin
        $display("%0d parcels arrived for %h where %0d were expected", got, t.adr, n_exp);
        errors++;
      end
      if (t.exp_fetch != ANY) check_value("biu_stb_o bursts", bursts - burst_base, t.exp_fetch);
      if (bursts - burst_base == 1) check_value("biu_adri_o", burst_adr, {t.adr[31:4], 4'h0});
      for (int j = 0; j < got && j < n_exp; j++) begin
        e = tests[i + j];
        check_value("parcel_o", par_word[par_base + j], e.exp_word);
        check_value("parcel_error_o", par_err[par_base + j], e.exp_err);
        if (bursts == burst_base) begin
          check_value("parcel_valid_o latency", par_cycle[par_base + j] - acc[j], 2);
        end
      end
      if (t.kind == PAIR && got == 2) begin
        check_value("parcel_valid_o gap", par_cycle[par_base + 1] - par_cycle[par_base], 1);
      end
      if (errors != errs_before) failed++;
      $display("test %0d at %h: %s", i, t.adr, (errors == errs_before) ? "ok" : "failed");
      if (t.kind == PAIR) i++;
    end
    $display("%0d tests, %0d failed, %0d errors", tests.size(), failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin : watchdog
    int limit;
    wait (rst_ni === 1'b1);
    limit = tests.size() * 200;
    repeat (limit) @(posedge clk_i);
    $display("timeout, the run did not finish within %0d cycles", limit);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
common/icache_pkg.sv
common/icache_fill_if.sv
icache/icache_memory.sv
icache/icache_biu_ctrl.sv
icache/icache_ctrl.sv
icache/icache_top.sv
test/tb_clk_gen.sv
test/tb_icache.sv

// ==== Bender.yml ====
package:
  name: icache

sources:
  - common/icache_pkg.sv
  - common/icache_fill_if.sv
  - icache/icache_memory.sv
  - icache/icache_biu_ctrl.sv
  - icache/icache_ctrl.sv
  - icache/icache_top.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_icache.sv
